// ==== p4_echo_router.f ====
+incdir+.
p4_echo_pkg.sv
ingress_gate.sv
port_fifo.sv
egress_stage.sv
csr_axil.sv
p4_echo_router_top.sv
p4_echo_router_assert.sv
p4_echo_router_tb.sv

// ==== p4_echo_router_tb.sv ====
// Testbench for the echo router
// Table-driven packets, AXI4-Lite register checks and an egress scoreboard

`include "p4_echo_config.svh"

module p4_echo_router_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import p4_echo_pkg::*;

    localparam int NP       = `P4E_NUM_PORTS;
    localparam int TIMEOUT  = 2000;
    localparam int PIPE_LAT = 3;
    localparam int NUM_ROWS = 10;

    typedef struct packed {
        logic [7:0] port;
        logic [7:0] beats;
        port_mask_t enable;
        logic       bp;
        port_mask_t clear;
    } stim_t;

    // port, beats, enable mask, back-pressure, clear mask
    stim_t stim_table [NUM_ROWS] = '{
        '{8'd0, 8'd4,  2'b11, 1'b0, 2'b00},
        '{8'd1, 8'd3,  2'b11, 1'b0, 2'b00},
        '{8'd1, 8'd5,  2'b01, 1'b0, 2'b00},
        '{8'd0, 8'd40, 2'b01, 1'b1, 2'b00},
        '{8'd1, 8'd20, 2'b11, 1'b1, 2'b00},
        '{8'd0, 8'd1,  2'b10, 1'b0, 2'b00},
        '{8'd0, 8'd6,  2'b11, 1'b0, 2'b01},
        '{8'd1, 8'd17, 2'b11, 1'b1, 2'b10},
        '{8'd1, 8'd2,  2'b00, 1'b0, 2'b00},
        '{8'd0, 8'd33, 2'b11, 1'b1, 2'b11}
    };

    logic                        phys_port_clk_ifc = 1'b0;
    logic                        rst;
    data_t [NP-1:0]              ing_tdata;
    port_mask_t                  ing_tvalid;
    port_mask_t                  ing_tlast;
    port_mask_t                  ing_tready;
    data_t [NP-1:0]              egr_tdata;
    port_mask_t                  egr_tvalid;
    port_mask_t                  egr_tlast;
    port_mask_t                  egr_tready;
    logic [`P4E_AXIL_ADDR_W-1:0] awaddr;
    logic                        awvalid;
    logic                        awready;
    logic [`P4E_AXIL_DATA_W-1:0] wdata;
    logic                        wvalid;
    logic                        wready;
    logic                        bvalid;
    logic                        bready;
    logic [1:0]                  bresp;
    logic [`P4E_AXIL_ADDR_W-1:0] araddr;
    logic                        arvalid;
    logic                        arready;
    logic                        rvalid;
    logic                        rready;
    logic [1:0]                  rresp;
    logic [`P4E_AXIL_DATA_W-1:0] rdata;

    logic [31:0]          pay_lfsr = 32'hb0bc_0f36;
    logic [31:0]          bp_lfsr  = 32'hb0bc_0f36;
    logic                 bp_on    = 1'b0;
    logic [`P4E_DATA_W:0] exp_q [NP][$];
    cnt_t                 cnt_exp [NP];
    port_mask_t           drop_exp;

    p4_echo_router_top dut0 (
        .clk (phys_port_clk_ifc), .rst (rst),
        .ing_tdata (ing_tdata), .ing_tvalid (ing_tvalid),
        .ing_tlast (ing_tlast), .ing_tready (ing_tready),
        .egr_tdata (egr_tdata), .egr_tvalid (egr_tvalid),
        .egr_tlast (egr_tlast), .egr_tready (egr_tready),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wvalid (wvalid), .wready (wready),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rvalid (rvalid), .rready (rready), .rresp (rresp), .rdata (rdata)
    );

    always #4 phys_port_clk_ifc = ~phys_port_clk_ifc;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic data_t next_payload();
        data_t d;
        d = '0;
        for (int i = 0; i < `P4E_DATA_W; i++) begin
            pay_lfsr = lfsr_next(pay_lfsr);
            d = {d[`P4E_DATA_W-2:0], pay_lfsr[0]};
        end
        return d;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_beat(input int port, input data_t got_d, input logic got_l,
                              input data_t exp_d, input logic exp_l);
        if (got_d !== exp_d) begin
            stop_run($sformatf("Fail egr_tdata[%0d] got %h expected %h", port, got_d, exp_d));
        end
        if (got_l !== exp_l) begin
            stop_run($sformatf("Fail egr_tlast[%0d] got %h expected %h", port, got_l, exp_l));
        end
    endtask

    task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_csr(input string name, input csr_word_u got, input csr_word_u exp);
        if (got.raw !== exp.raw) begin
            stop_run($sformatf("Fail %s got %h expected %h", name, got.raw, exp.raw));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite master, entered and left 1 ns after a rising edge

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        int n;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        do begin
            @(posedge phys_port_clk_ifc);
            n++;
            if (n > TIMEOUT) stop_run("Write address and data were never accepted");
        end while (!(awready && wready));
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        do begin
            @(posedge phys_port_clk_ifc);
            n++;
            if (n > TIMEOUT) stop_run("Write response never arrived");
        end while (!bvalid);
        if (bresp !== 2'b00) begin
            stop_run($sformatf("Fail bresp got %h expected %h", bresp, 2'b00));
        end
        #1;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            @(posedge phys_port_clk_ifc);
            n++;
            if (n > TIMEOUT) stop_run("Read address was never accepted");
        end while (!arready);
        #1;
        arvalid = 1'b0;
        n = 0;
        do begin
            @(posedge phys_port_clk_ifc);
            n++;
            if (n > TIMEOUT) stop_run("Read data never arrived");
        end while (!rvalid);
        data = rdata;
        if (rresp !== 2'b00) begin
            stop_run($sformatf("Fail rresp got %h expected %h", rresp, 2'b00));
        end
        #1;
    endtask

    task automatic check_counters();
        logic [31:0] word;
        for (int p = 0; p < NP; p++) begin
            read_reg(8'(4 + 8 * p), word);
            if (word[31:`P4E_CNT_W] != '0) begin
                stop_run($sformatf("Fail rdata[31:%0d] of ing_cnt[%0d] got %h expected 0",
                                   `P4E_CNT_W, p, word[31:`P4E_CNT_W]));
            end
            check_cnt($sformatf("ing_cnt[%0d]", p), cnt_t'(word), cnt_exp[p]);
            read_reg(8'(8 + 8 * p), word);
            if (word[31:`P4E_CNT_W] != '0) begin
                stop_run($sformatf("Fail rdata[31:%0d] of egr_cnt[%0d] got %h expected 0",
                                   `P4E_CNT_W, p, word[31:`P4E_CNT_W]));
            end
            check_cnt($sformatf("egr_cnt[%0d]", p), cnt_t'(word), cnt_exp[p]);
        end
    endtask

    task automatic check_ctrl(input port_mask_t enable);
        logic [31:0] word;
        csr_word_u   got;
        csr_word_u   exp;
        read_reg(8'h00, word);
        got.raw       = word;
        exp.raw       = '0;
        exp.rd.enable = enable;
        exp.rd.drop   = drop_exp;
        check_csr("rdata at 0x00", got, exp);
        drop_exp = '0;
    endtask

    task automatic send_packet(input int port, input int beats, input logic enabled);
        data_t d;
        int    n;
        for (int b = 0; b < beats; b++) begin
            d = next_payload();
            ing_tdata[port]  = d;
            ing_tlast[port]  = (b == beats - 1);
            ing_tvalid[port] = 1'b1;
            n = 0;
            do begin
                @(posedge phys_port_clk_ifc);
                n++;
                if (n > TIMEOUT) stop_run("Ingress beat was never accepted");
            end while (!ing_tready[port]);
            if (enabled) exp_q[port].push_back({ing_tlast[port], d});
            #1;
        end
        ing_tvalid[port] = 1'b0;
        ing_tlast[port]  = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(posedge phys_port_clk_ifc);
            n++;
            if (n > TIMEOUT) stop_run("Expected egress beats never arrived");
        end
        // A stray beat of a dropped packet would show up within the pipeline latency
        repeat (PIPE_LAT + 1) @(posedge phys_port_clk_ifc);
        bp_on = 1'b0;
        #1;
    endtask

    // Egress back-pressure, random while enabled
    always @(posedge phys_port_clk_ifc) begin
        #1;
        for (int p = 0; p < NP; p++) begin
            if (bp_on) begin
                bp_lfsr = lfsr_next(bp_lfsr);
                egr_tready[p] = bp_lfsr[0];
            end else begin
                egr_tready[p] = 1'b1;
            end
        end
    end

    // Scoreboard
    always @(posedge phys_port_clk_ifc) begin
        logic [`P4E_DATA_W:0] e;
        if (!rst) begin
            for (int p = 0; p < NP; p++) begin
                if (egr_tvalid[p] && egr_tready[p]) begin
                    if (exp_q[p].size() == 0) begin
                        stop_run($sformatf("Unexpected beat on egress port %0d", p));
                    end
                    e = exp_q[p].pop_front();
                    check_beat(p, egr_tdata[p], egr_tlast[p],
                               e[`P4E_DATA_W-1:0], e[`P4E_DATA_W]);
                end
            end
        end
    end

    always @(dut0.p4_echo_router_assert0.err_cnt) begin
        if (dut0.p4_echo_router_assert0.err_cnt != 0) begin
            stop_run("A protocol assertion on the DUT failed");
        end
    end

    initial begin
        stim_t     row;
        csr_word_u w;
        rst        = 1'b1;
        ing_tdata  = '0;
        ing_tvalid = '0;
        ing_tlast  = '0;
        egr_tready = '1;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b1;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b1;
        drop_exp   = '0;
        for (int p = 0; p < NP; p++) cnt_exp[p] = '0;

        repeat (8) @(posedge phys_port_clk_ifc);
        #1;
        rst = 1'b0;
        check_ctrl('0);
        check_counters();

        for (int i = 0; i < NUM_ROWS; i++) begin
            row         = stim_table[i];
            w.raw       = '0;
            w.wr.enable = row.enable;
            w.wr.clear  = row.clear;
            write_reg(8'h00, w.raw);
            for (int p = 0; p < NP; p++) begin
                if (row.clear[p]) cnt_exp[p] = '0;
            end
            if (row.clear != '0) check_counters();
            // Also shows the drop flags of the previous row were cleared
            check_ctrl(row.enable);

            @(posedge phys_port_clk_ifc);
            bp_on = row.bp;
            #1;
            send_packet(row.port, row.beats, row.enable[row.port]);
            if (row.enable[row.port]) begin
                cnt_exp[row.port] = cnt_exp[row.port] + 1'b1;
            end else begin
                drop_exp[row.port] = 1'b1;
            end
            wait_drain();
            check_counters();
            check_ctrl(row.enable);
        end
        check_ctrl(stim_table[NUM_ROWS-1].enable);

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== p4_echo_router_assert.sv ====
// Protocol checks for the echo router
// Egress stability under back-pressure and AXI4-Lite response rules

`include "p4_echo_config.svh"

module p4_echo_router_assert (
    input logic                                    clk,
    input logic                                    rst,
    input p4_echo_pkg::data_t [`P4E_NUM_PORTS-1:0] egr_tdata,
    input p4_echo_pkg::port_mask_t                 egr_tvalid,
    input p4_echo_pkg::port_mask_t                 egr_tlast,
    input p4_echo_pkg::port_mask_t                 egr_tready,
    input logic                                    awready,
    input logic                                    bvalid,
    input logic                                    rvalid
);
    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed assertions so far
    int err_cnt = 0;

    for (genvar p = 0; p < `P4E_NUM_PORTS; p++) begin : g_port
        // Held beat must not change until it transfers
        a_egr_stable : assert property (@(posedge clk) disable iff (rst)
            egr_tvalid[p] && !egr_tready[p] |=>
                egr_tvalid[p] && $stable(egr_tdata[p]) && $stable(egr_tlast[p]))
            else begin
                $error("egress beat on port %0d changed under back-pressure", p);
                err_cnt++;
            end
    end

    a_resp_reset : assert property (@(posedge clk) rst |=> !bvalid && !rvalid)
        else begin
            $error("bvalid or rvalid high during reset");
            err_cnt++;
        end

    a_aw_pending : assert property (@(posedge clk) disable iff (rst) !(awready && bvalid))
        else begin
            $error("awready high while a write response is pending");
            err_cnt++;
        end

endmodule

bind p4_echo_router_top p4_echo_router_assert p4_echo_router_assert0 (
    .clk        (clk),
    .rst        (rst),
    .egr_tdata  (egr_tdata),
    .egr_tvalid (egr_tvalid),
    .egr_tlast  (egr_tlast),
    .egr_tready (egr_tready),
    .awready    (awready),
    .bvalid     (bvalid),
    .rvalid     (rvalid)
);

// ==== p4_echo_router_top.sv ====
// Two-port packet echo path
// Each ingress port returns its packets on the egress port of the same index

`include "p4_echo_config.svh"

module p4_echo_router_top (
    input  logic                                    clk,
    input  logic                                    rst,
    input  p4_echo_pkg::data_t [`P4E_NUM_PORTS-1:0] ing_tdata,
    input  p4_echo_pkg::port_mask_t                 ing_tvalid,
    input  p4_echo_pkg::port_mask_t                 ing_tlast,
    output p4_echo_pkg::port_mask_t                 ing_tready,
    output p4_echo_pkg::data_t [`P4E_NUM_PORTS-1:0] egr_tdata,
    output p4_echo_pkg::port_mask_t                 egr_tvalid,
    output p4_echo_pkg::port_mask_t                 egr_tlast,
    input  p4_echo_pkg::port_mask_t                 egr_tready,
    input  logic [`P4E_AXIL_ADDR_W-1:0]             awaddr,
    input  logic                                    awvalid,
    output logic                                    awready,
    input  logic [`P4E_AXIL_DATA_W-1:0]             wdata,
    input  logic                                    wvalid,
    output logic                                    wready,
    output logic                                    bvalid,
    input  logic                                    bready,
    output logic [1:0]                              bresp,
    input  logic [`P4E_AXIL_ADDR_W-1:0]             araddr,
    input  logic                                    arvalid,
    output logic                                    arready,
    output logic                                    rvalid,
    input  logic                                    rready,
    output logic [1:0]                              rresp,
    output logic [`P4E_AXIL_DATA_W-1:0]             rdata
);
    import p4_echo_pkg::*;

    data_t [`P4E_NUM_PORTS-1:0] gate_tdata;
    port_mask_t                 gate_tvalid;
    port_mask_t                 gate_tlast;
    port_mask_t                 gate_tready;
    data_t [`P4E_NUM_PORTS-1:0] fifo_tdata;
    port_mask_t                 fifo_tvalid;
    port_mask_t                 fifo_tlast;
    port_mask_t                 fifo_tready;
    port_mask_t                 port_enable;
    port_mask_t                 cnt_clear;
    port_mask_t                 pkt_dropped;
    cnt_t [`P4E_NUM_PORTS-1:0]  ing_cnt;
    cnt_t [`P4E_NUM_PORTS-1:0]  egr_cnt;

    ingress_gate ingress_gate0 (
        .clk         (clk),
        .rst         (rst),
        .ing_tdata   (ing_tdata),
        .ing_tvalid  (ing_tvalid),
        .ing_tlast   (ing_tlast),
        .ing_tready  (ing_tready),
        .port_enable (port_enable),
        .cnt_clear   (cnt_clear),
        .gate_tdata  (gate_tdata),
        .gate_tvalid (gate_tvalid),
        .gate_tlast  (gate_tlast),
        .gate_tready (gate_tready),
        .ing_cnt     (ing_cnt),
        .pkt_dropped (pkt_dropped)
    );

    // One buffer per port
    for (genvar p = 0; p < `P4E_NUM_PORTS; p++) begin : g_fifo
        port_fifo #(
            .DEPTH (`P4E_FIFO_DEPTH)
        ) port_fifo0 (
            .clk        (clk),
            .rst        (rst),
            .in_tdata   (gate_tdata[p]),
            .in_tvalid  (gate_tvalid[p]),
            .in_tlast   (gate_tlast[p]),
            .in_tready  (gate_tready[p]),
            .out_tdata  (fifo_tdata[p]),
            .out_tvalid (fifo_tvalid[p]),
            .out_tlast  (fifo_tlast[p]),
            .out_tready (fifo_tready[p])
        );
    end

    egress_stage egress_stage0 (
        .clk         (clk),
        .rst         (rst),
        .fifo_tdata  (fifo_tdata),
        .fifo_tvalid (fifo_tvalid),
        .fifo_tlast  (fifo_tlast),
        .fifo_tready (fifo_tready),
        .egr_tdata   (egr_tdata),
        .egr_tvalid  (egr_tvalid),
        .egr_tlast   (egr_tlast),
        .egr_tready  (egr_tready),
        .cnt_clear   (cnt_clear),
        .egr_cnt     (egr_cnt)
    );

    csr_axil csr_axil0 (
        .clk         (clk),
        .rst         (rst),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rvalid      (rvalid),
        .rready      (rready),
        .rresp       (rresp),
        .rdata       (rdata),
        .ing_cnt     (ing_cnt),
        .egr_cnt     (egr_cnt),
        .pkt_dropped (pkt_dropped),
        .port_enable (port_enable),
        .cnt_clear   (cnt_clear)
    );

endmodule

// ==== csr_axil.sv ====
// AXI4-Lite register slave
// Port enables, counter clears, sticky drop flags and counter readback

`include "p4_echo_config.svh"

module csr_axil (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [`P4E_AXIL_ADDR_W-1:0]            awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [`P4E_AXIL_DATA_W-1:0]            wdata,
    input  logic                                   wvalid,
    output logic                                   wready,
    output logic                                   bvalid,
    input  logic                                   bready,
    output logic [1:0]                             bresp,
    input  logic [`P4E_AXIL_ADDR_W-1:0]            araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic                                   rvalid,
    input  logic                                   rready,
    output logic [1:0]                             rresp,
    output logic [`P4E_AXIL_DATA_W-1:0]            rdata,
    input  p4_echo_pkg::cnt_t [`P4E_NUM_PORTS-1:0] ing_cnt,
    input  p4_echo_pkg::cnt_t [`P4E_NUM_PORTS-1:0] egr_cnt,
    input  p4_echo_pkg::port_mask_t                pkt_dropped,
    output p4_echo_pkg::port_mask_t                port_enable,
    output p4_echo_pkg::port_mask_t                cnt_clear
);
    import p4_echo_pkg::*;

    localparam int AW = `P4E_AXIL_ADDR_W;
    localparam int DW = `P4E_AXIL_DATA_W;

    port_mask_t drop_flags;
    csr_word_u  wr_word;
    csr_word_u  rd_word;
    logic       wr_acc;
    logic       rd_acc;
    logic       wr_ctrl;
    logic       rd_ctrl;

    //////////////////////////////////////////////////////////////////////
    // Write channel

    assign wr_acc  = awvalid && wvalid && !bvalid;
    assign awready = wr_acc;
    assign wready  = wr_acc;
    assign bresp   = 2'b00;

    assign wr_word.raw = wdata;
    assign wr_ctrl     = wr_acc && (awaddr == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid      <= 1'b0;
            port_enable <= '0;
            cnt_clear   <= '0;
        end else begin
            if (wr_acc) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            // Clear is a single-cycle pulse
            cnt_clear <= wr_ctrl ? wr_word.wr.clear : '0;
            if (wr_ctrl) begin
                port_enable <= wr_word.wr.enable;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read channel

    assign arready = !rvalid;
    assign rd_acc  = arvalid && arready;
    assign rd_ctrl = rd_acc && (araddr == '0);
    assign rresp   = 2'b00;

    always_comb begin
        rd_word = '0;
        if (araddr == '0) begin
            rd_word.rd.enable = port_enable;
            rd_word.rd.drop   = drop_flags;
        end
        for (int p = 0; p < `P4E_NUM_PORTS; p++) begin
            if (araddr == AW'(4 + 8 * p)) begin
                rd_word.raw = DW'(ing_cnt[p]);
            end
            if (araddr == AW'(8 + 8 * p)) begin
                rd_word.raw = DW'(egr_cnt[p]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid     <= 1'b0;
            drop_flags <= '0;
        end else begin
            if (rd_acc) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            // A drop in the same cycle as the read survives it
            drop_flags <= (rd_ctrl ? '0 : drop_flags) | pkt_dropped;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rdata <= rd_word.raw;
        end
    end

endmodule

// ==== egress_stage.sv ====
// Egress output registers for all ports
// Holds one beat per port under back-pressure and counts sent packets

`include "p4_echo_config.svh"

module egress_stage (
    input  logic                                    clk,
    input  logic                                    rst,
    input  p4_echo_pkg::data_t [`P4E_NUM_PORTS-1:0] fifo_tdata,
    input  p4_echo_pkg::port_mask_t                 fifo_tvalid,
    input  p4_echo_pkg::port_mask_t                 fifo_tlast,
    output p4_echo_pkg::port_mask_t                 fifo_tready,
    output p4_echo_pkg::data_t [`P4E_NUM_PORTS-1:0] egr_tdata,
    output p4_echo_pkg::port_mask_t                 egr_tvalid,
    output p4_echo_pkg::port_mask_t                 egr_tlast,
    input  p4_echo_pkg::port_mask_t                 egr_tready,
    input  p4_echo_pkg::port_mask_t                 cnt_clear,
    output p4_echo_pkg::cnt_t [`P4E_NUM_PORTS-1:0]  egr_cnt
);
    import p4_echo_pkg::*;

    port_mask_t load;
    port_mask_t xfer;

    assign fifo_tready = ~egr_tvalid | egr_tready;
    assign load        = fifo_tvalid & fifo_tready;
    assign xfer        = egr_tvalid & egr_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            egr_tvalid <= '0;
            egr_cnt    <= '0;
        end else begin
            for (int p = 0; p < `P4E_NUM_PORTS; p++) begin
                if (load[p]) begin
                    egr_tvalid[p] <= 1'b1;
                end else if (egr_tready[p]) begin
                    egr_tvalid[p] <= 1'b0;
                end

                // Count on the last beat leaving
                if (cnt_clear[p]) begin
                    egr_cnt[p] <= '0;
                end else if (xfer[p] && egr_tlast[p]) begin
                    egr_cnt[p] <= egr_cnt[p] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `P4E_NUM_PORTS; p++) begin
            if (load[p]) begin
                egr_tdata[p] <= fifo_tdata[p];
                egr_tlast[p] <= fifo_tlast[p];
            end
        end
    end

endmodule

// ==== port_fifo.sv ====
// Beat FIFO for one port
// Holds data and last, first word falls through to the output

module port_fifo #(
    parameter int DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  p4_echo_pkg::data_t in_tdata,
    input  logic               in_tvalid,
    input  logic               in_tlast,
    output logic               in_tready,
    output p4_echo_pkg::data_t out_tdata,
    output logic               out_tvalid,
    output logic               out_tlast,
    input  logic               out_tready
);
    import p4_echo_pkg::*;

    localparam int AW = $clog2(DEPTH);

    data_t       mem_data [DEPTH];
    logic        mem_last [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        push;
    logic        pop;

    // Same index, different wrap bit
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign in_tready  = !full;
    assign out_tvalid = !empty;
    assign push       = in_tvalid && in_tready;
    assign pop        = out_tvalid && out_tready;

    assign out_tdata = mem_data[rd_ptr[AW-1:0]];
    assign out_tlast = mem_last[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr[AW-1:0]] <= in_tdata;
            mem_last[wr_ptr[AW-1:0]] <= in_tlast;
        end
    end

endmodule

// ==== ingress_gate.sv ====
// Ingress gate for all ports
// Latches the port enable per packet, drops disabled packets and counts the rest

`include "p4_echo_config.svh"

module ingress_gate (
    input  logic                                    clk,
    input  logic                                    rst,
    input  p4_echo_pkg::data_t [`P4E_NUM_PORTS-1:0] ing_tdata,
    input  p4_echo_pkg::port_mask_t                 ing_tvalid,
    input  p4_echo_pkg::port_mask_t                 ing_tlast,
    output p4_echo_pkg::port_mask_t                 ing_tready,
    input  p4_echo_pkg::port_mask_t                 port_enable,
    input  p4_echo_pkg::port_mask_t                 cnt_clear,
    output p4_echo_pkg::data_t [`P4E_NUM_PORTS-1:0] gate_tdata,
    output p4_echo_pkg::port_mask_t                 gate_tvalid,
    output p4_echo_pkg::port_mask_t                 gate_tlast,
    input  p4_echo_pkg::port_mask_t                 gate_tready,
    output p4_echo_pkg::cnt_t [`P4E_NUM_PORTS-1:0]  ing_cnt,
    output p4_echo_pkg::port_mask_t                 pkt_dropped
);
    import p4_echo_pkg::*;

    port_mask_t in_pkt;
    port_mask_t pkt_en;
    port_mask_t beat_en;
    port_mask_t accept;

    assign ing_tready = ~gate_tvalid | gate_tready;
    assign accept     = ing_tvalid & ing_tready;

    // First beat uses the live enable, later beats the latched one
    assign beat_en = (in_pkt & pkt_en) | (~in_pkt & port_enable);

    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt      <= '0;
            pkt_en      <= '0;
            gate_tvalid <= '0;
            pkt_dropped <= '0;
            ing_cnt     <= '0;
        end else begin
            pkt_dropped <= accept & ~beat_en & ing_tlast;
            for (int p = 0; p < `P4E_NUM_PORTS; p++) begin
                if (accept[p]) begin
                    in_pkt[p] <= !ing_tlast[p];
                    if (!in_pkt[p]) begin
                        pkt_en[p] <= port_enable[p];
                    end
                end

                if (accept[p] && beat_en[p]) begin
                    gate_tvalid[p] <= 1'b1;
                end else if (gate_tready[p]) begin
                    gate_tvalid[p] <= 1'b0;
                end

                if (cnt_clear[p]) begin
                    ing_cnt[p] <= '0;
                end else if (accept[p] && beat_en[p] && ing_tlast[p]) begin
                    ing_cnt[p] <= ing_cnt[p] + 1'b1;
                end
            end
        end
    end

    // Beat register
    always_ff @(posedge clk) begin
        for (int p = 0; p < `P4E_NUM_PORTS; p++) begin
            if (accept[p] && beat_en[p]) begin
                gate_tdata[p] <= ing_tdata[p];
                gate_tlast[p] <= ing_tlast[p];
            end
        end
    end

endmodule

// ==== p4_echo_pkg.sv ====
// Echo router types
// Stream beats, counters, port masks and the two views of the control word

`include "p4_echo_config.svh"

package p4_echo_pkg;

    typedef logic [`P4E_DATA_W-1:0]    data_t;
    typedef logic [`P4E_CNT_W-1:0]     cnt_t;
    typedef logic [`P4E_NUM_PORTS-1:0] port_mask_t;

    //////////////////////////////////////////////////////////////////////
    // Control word at 0x00

    // Write side, enables in 1:0 and clear pulses in 9:8
    typedef struct packed {
        logic [`P4E_AXIL_DATA_W-`P4E_NUM_PORTS-9:0] rsvd_hi;
        port_mask_t                                 clear;
        logic [7-`P4E_NUM_PORTS:0]                  rsvd_lo;
        port_mask_t                                 enable;
    } csr_ctrl_wr_t;

    // Read side, enables in 1:0 and sticky drops in 17:16
    typedef struct packed {
        logic [`P4E_AXIL_DATA_W-`P4E_NUM_PORTS-17:0] zero_hi;
        port_mask_t                                  drop;
        logic [15-`P4E_NUM_PORTS:0]                  zero_lo;
        port_mask_t                                  enable;
    } csr_status_rd_t;

    typedef union packed {
        csr_ctrl_wr_t               wr;
        csr_status_rd_t             rd;
        logic [`P4E_AXIL_DATA_W-1:0] raw;
    } csr_word_u;

endpackage

// ==== p4_echo_config.svh ====
// Echo router build configuration
// Port count, stream, FIFO, counter and AXI4-Lite sizes

`ifndef P4_ECHO_CONFIG_SVH
`define P4_ECHO_CONFIG_SVH

// Physical ports, one stream width for all of them
`define P4E_NUM_PORTS    2
`define P4E_DATA_W       32

// Beats held per port, power of two
`define P4E_FIFO_DEPTH   16

// Packet counters
`define P4E_CNT_W        16

// Register slave
`define P4E_AXIL_ADDR_W  8
`define P4E_AXIL_DATA_W  32

`endif
